//--- bench/fuse_guard_chk.sv
// Concurrent assertions on discard and program timing, bound into the fuse guard top level.

`timescale 1ns/1ps
`default_nettype none

module fuse_guard_chk (
    input wire clk_i,
    input wire rst_n_i,
    input wire init_done_i,
    input wire discard_i,
    input wire prog_done_i,
    input wire write_discarded_i
);
    int fail_count = 0;

    // A command ends either programmed or dropped, never both.
    a_one_outcome: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(prog_done_i && write_discarded_i))
        else begin
            fail_count++;
            $error("program and discard pulses in the same cycle");
        end

    // The programmer only drops a command while the filter holds discard.
    a_discard_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_discarded_i |-> $past(discard_i))
        else begin
            fail_count++;
            $error("discard acknowledge without discard in the cycle before");
        end

    // Before fuse initialization the filter stays in its reset state.
    a_quiet_before_init: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !init_done_i |-> !discard_i)
        else begin
            fail_count++;
            $error("discard raised before init done");
        end

endmodule

bind fuse_guard_top fuse_guard_chk u_chk (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .init_done_i(init_done_i),
    .discard_i(discard), .prog_done_i(prog_done_o), .write_discarded_i(write_discarded_o)
);

`default_nettype wire

//--- bench/fuse_guard_monitor.sv
// Testbench monitor; compares DUT outputs with the expected values and prints a line per test.

`timescale 1ns/1ps
`include "fuse_guard_cfg.svh"
`default_nettype none

module fuse_guard_monitor (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        prog_done_i,
    input  wire                        write_discarded_i,
    input  wire  [2*`FG_DATA_W-1:0]    rd_data_i,
    input  wire                        exp_prog_i,
    input  wire                        exp_disc_i,
    input  wire                        exp_rd_valid_i,
    input  wire  [2*`FG_DATA_W-1:0]    exp_rd_data_i,
    input  wire                        test_end_i,
    input  wire  [2:0]                 test_id_i,
    output logic [31:0]                errors_o,
    output logic [31:0]                checks_o
);
    int err_cnt = 0;
    int chk_cnt = 0;
    int test_start_errs = 0;

    assign errors_o = err_cnt;
    assign checks_o = chk_cnt;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "reset readback";
            3'd2: return "owner programs";
            3'd3: return "refused owner or word";
            3'd4: return "mixed users";
            3'd5: return "nop command";
            default: return "random mix";
        endcase
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic compare_word(input string name, input logic [2*`FG_DATA_W-1:0] got,
                                input logic [2*`FG_DATA_W-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // The falling edge sits halfway between the DUT update and the next stimulus.
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            compare_bit("prog_done_o", prog_done_i, exp_prog_i);
            compare_bit("write_discarded_o", write_discarded_i, exp_disc_i);
            if (exp_rd_valid_i) begin
                compare_word("rd_data_o", rd_data_i, exp_rd_data_i);
            end
            if (test_end_i) begin
                $display("test %0d %s done: %0d errors", test_id_i, test_name(test_id_i),
                         err_cnt - test_start_errs);
                test_start_errs = err_cnt;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/fuse_guard_tb.sv
// Testbench top for the fuse write guard; drives directed and random fuse commands against a model.

`timescale 1ns/1ps
`include "fuse_guard_cfg.svh"
`default_nettype none

module fuse_guard_tb;
    import fuse_guard_pkg::*;

    localparam int clk_period = 10;
    localparam int n_random   = 200;
    localparam int n_txn      = 28 + n_random;
    localparam logic [`FG_USER_W-1:0] strap0 = 8'h3a;
    localparam logic [`FG_USER_W-1:0] strap1 = 8'hc5;

    logic                    clk;
    logic                    rst_n;
    logic                    bus_aw;
    logic [`FG_ADDR_W-1:0]   bus_addr;
    logic [`FG_USER_W-1:0]   bus_user;
    logic                    bus_w;
    logic [`FG_DATA_W-1:0]   bus_wdata;
    logic                    init_done;
    logic [`FG_FUSE_AW-1:0]  rd_addr;
    logic [2*`FG_DATA_W-1:0] rd_data;
    logic                    prog_done;
    logic                    write_discarded;
    logic                    exp_prog;
    logic                    exp_disc;
    logic                    exp_rd_valid;
    logic [2*`FG_DATA_W-1:0] exp_rd_data;
    logic                    test_end;
    logic [2:0]              test_id;
    logic [31:0]             errors;
    logic [31:0]             checks;
    logic [31:0]             lcg_state;
    logic [2*`FG_DATA_W-1:0] model_fuse [`FG_FUSE_WORDS];

    fuse_guard_top dut_i (
        .clk_i(clk), .rst_n_i(rst_n),
        .bus_aw_i(bus_aw), .bus_addr_i(bus_addr), .bus_user_i(bus_user),
        .bus_w_i(bus_w), .bus_wdata_i(bus_wdata),
        .strap_user0_i(strap0), .strap_user1_i(strap1), .init_done_i(init_done),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .prog_done_o(prog_done), .write_discarded_o(write_discarded)
    );

    fuse_guard_monitor mon_i (
        .clk_i(clk), .rst_n_i(rst_n),
        .prog_done_i(prog_done), .write_discarded_i(write_discarded), .rd_data_i(rd_data),
        .exp_prog_i(exp_prog), .exp_disc_i(exp_disc),
        .exp_rd_valid_i(exp_rd_valid), .exp_rd_data_i(exp_rd_data),
        .test_end_i(test_end), .test_id_i(test_id),
        .errors_o(errors), .checks_o(checks)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Every transaction fits well inside 40 cycles, so this only trips on a hang.
    initial begin
        repeat (n_txn * 40 + 200) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", n_txn * 40 + 200);
        $display("sim failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers and the reference rules.
    // ------------------------------------------------------------------------

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // A command passes when one user made all four writes and owns the word.
    function automatic logic cmd_allowed(input logic [`FG_USER_W-1:0] u0, u1, u2, u3,
                                         input int widx);
        logic same_user;
        logic owned;
        same_user = (u0 == u1) && (u1 == u2) && (u2 == u3);
        owned = ((widx >= `FG_RANGE0_LO) && (widx <= `FG_RANGE0_HI) && (u0 == strap0))
              || ((widx >= `FG_RANGE1_LO) && (widx <= `FG_RANGE1_HI) && (u0 == strap1));
        return same_user && owned;
    endfunction

    // The data beat follows one cycle after the address beat and stays up
    // until the next call or idle cycle lowers it.
    task automatic write_reg(input logic [`FG_ADDR_W-1:0] ofs,
                             input logic [`FG_USER_W-1:0] user,
                             input logic [`FG_DATA_W-1:0] data);
        @(posedge clk);
        #1;
        bus_aw   = 1'b1;
        bus_w    = 1'b0;
        bus_addr = ofs;
        bus_user = user;
        @(posedge clk);
        #1;
        bus_aw    = 1'b0;
        bus_w     = 1'b1;
        bus_wdata = data;
    endtask

    task automatic step_cycle(input logic pulse_prog, input logic pulse_disc);
        @(posedge clk);
        #1;
        bus_aw   = 1'b0;
        bus_w    = 1'b0;
        exp_prog = pulse_prog;
        exp_disc = pulse_disc;
    endtask

    // Readback lands one cycle after the address, so the expectation trails it.
    task automatic read_check(input logic [`FG_FUSE_AW-1:0] a);
        @(posedge clk);
        #1;
        rd_addr = a;
        @(posedge clk);
        #1;
        exp_rd_data  = model_fuse[a];
        exp_rd_valid = 1'b1;
        @(posedge clk);
        #1;
        exp_rd_valid = 1'b0;
    endtask

    task automatic end_test(input logic [2:0] id);
        @(posedge clk);
        #1;
        test_id  = id;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    // Kind 0 is a legal program, 1 a refused owner or word, 2 mixed users, 3 a NOP.
    task automatic run_txn(input int kind);
        logic [3:0][`FG_USER_W-1:0] usr;
        logic [`FG_USER_W-1:0]      owner;
        logic [`FG_FUSE_AW-1:0]     fa;
        logic [31:0]                r;
        logic [`FG_DATA_W-1:0]      cmd;
        logic [`FG_DATA_W-1:0]      w0;
        logic [`FG_DATA_W-1:0]      w1;
        logic                       ok;
        logic                       prog;
        r = next_rand();
        if (r[31]) begin
            fa    = 5'(`FG_RANGE1_LO + int'(r[29:24]) % (`FG_RANGE1_HI - `FG_RANGE1_LO + 1));
            owner = strap1;
        end else begin
            fa    = 5'(`FG_RANGE0_LO + int'(r[27:24]));
            owner = strap0;
        end
        usr = {4{owner}};
        if (kind == 1) begin
            if (r[30]) begin
                // The two top words sit outside every range.
                fa  = 5'(`FG_RANGE1_HI + 1 + int'(r[23]));
                usr = {4{r[22] ? strap0 : strap1}};
            end else begin
                usr = {4{r[31] ? strap0 : strap1}};
            end
        end
        if (kind == 2) begin
            usr[r[21:20]] = usr[r[21:20]] ^ 8'(1 + int'(r[19:14]));
        end
        // Sparse data keeps the OR-accumulated words from filling up too fast.
        w0       = next_rand() & next_rand();
        w1       = next_rand() & next_rand();
        cmd      = next_rand();
        cmd[1:0] = (kind == 3) ? CMD_NOP : CMD_PROGRAM;
        ok   = cmd_allowed(usr[0], usr[1], usr[2], usr[3], int'(fa));
        prog = ok && (cmd[1:0] == CMD_PROGRAM);
        write_reg(`FG_OFS_WDATA0, usr[0], w0);
        write_reg(`FG_OFS_WDATA1, usr[1], w1);
        write_reg(`FG_OFS_ADDRESS, usr[2], {27'd0, fa});
        write_reg(`FG_OFS_CMD, usr[3], cmd);
        // The outcome pulse is high in the fourth cycle after the command address beat.
        step_cycle(1'b0, 1'b0);
        step_cycle(1'b0, 1'b0);
        step_cycle(prog, !ok);
        step_cycle(1'b0, 1'b0);
        if (prog) begin
            model_fuse[fa] = model_fuse[fa] | {w1, w0};
        end
        read_check(fa);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] pick;
        rst_n        = 1'b0;
        init_done    = 1'b0;
        bus_aw       = 1'b0;
        bus_addr     = '0;
        bus_user     = '0;
        bus_w        = 1'b0;
        bus_wdata    = '0;
        rd_addr      = '0;
        exp_prog     = 1'b0;
        exp_disc     = 1'b0;
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
        test_end     = 1'b0;
        test_id      = 3'd0;
        lcg_state    = 32'hba2f5818;
        for (int i = 0; i < `FG_FUSE_WORDS; i++) begin
            model_fuse[5'(i)] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        init_done = 1'b1;
        // Every word reads back blank before the first program.
        for (int i = 0; i < `FG_FUSE_WORDS; i++) begin
            read_check(5'(i));
        end
        end_test(3'd1);
        repeat (8) run_txn(0);
        end_test(3'd2);
        repeat (8) run_txn(1);
        end_test(3'd3);
        repeat (8) run_txn(2);
        end_test(3'd4);
        repeat (4) run_txn(3);
        end_test(3'd5);
        for (int i = 0; i < n_random; i++) begin
            pick = next_rand();
            run_txn(int'(pick[31:30]));
        end
        end_test(3'd6);
        $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, dut_i.u_chk.fail_count);
        if (errors == 0 && dut_i.u_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/fuse_guard_cfg.svh
// Widths, register map, fuse depth and access table of the fuse write guard; include before use.

`ifndef FUSE_GUARD_CFG_SVH
`define FUSE_GUARD_CFG_SVH

`default_nettype none

// Bus widths of the snooped write bus.
`define FG_ADDR_W 8
`define FG_USER_W 8
`define FG_DATA_W 32

// Offsets of the direct-access register window.
`define FG_OFS_WDATA0  8'h00
`define FG_OFS_WDATA1  8'h04
`define FG_OFS_ADDRESS 8'h08
`define FG_OFS_CMD     8'h0C

// The fuse array holds 64-bit words, built from the two data registers.
`define FG_FUSE_WORDS 32
`define FG_FUSE_AW    5

// Range 0 belongs to strap user 0.
`define FG_RANGE0_LO 0
`define FG_RANGE0_HI 15

// Range 1 belongs to strap user 1.
// Words 30 and 31 lie outside both ranges, so no user may program them.
`define FG_RANGE1_LO 16
`define FG_RANGE1_HI 29

`default_nettype wire

`endif

//--- common/fuse_guard_pkg.sv
// Shared enum types for the fuse write guard; each stage imports the ones it needs.

`default_nettype none

package fuse_guard_pkg;

    // States of the snooping filter FSM.
    // They follow the order in which the host writes the direct-access registers.
    typedef enum logic [2:0] {
        RESET_ST              = 3'd0,
        IDLE_ST               = 3'd1,
        WDATA_ADDR_ST         = 3'd2,
        WDATA_ST              = 3'd3,
        FUSE_ADDR_AXI_ADDR_ST = 3'd4,
        FUSE_ADDR_AXI_WR_ST   = 3'd5,
        FUSE_CMD_AXI_ADDR_ST  = 3'd6,
        DISCARD_ST            = 3'd7
    } filter_state_t;

    // Register targeted by a bus write, as decoded from its address beat.
    typedef enum logic [2:0] {
        REG_NONE    = 3'd0,
        REG_WDATA0  = 3'd1,
        REG_WDATA1  = 3'd2,
        REG_ADDRESS = 3'd3,
        REG_CMD     = 3'd4
    } reg_sel_t;

    // Command opcode, taken from the two low bits of the command data word.
    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,
        CMD_PROGRAM = 2'd1
    } fuse_cmd_t;

endpackage

`default_nettype wire

//--- design/fuse_bus_decode.sv
// First pipeline stage; turns strobed address and data beats into paired register writes.

`timescale 1ns/1ps
`include "fuse_guard_cfg.svh"
`default_nettype none

module fuse_bus_decode (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        bus_aw_i,
    input  wire  [`FG_ADDR_W-1:0]      bus_addr_i,
    input  wire  [`FG_USER_W-1:0]      bus_user_i,
    input  wire                        bus_w_i,
    input  wire  [`FG_DATA_W-1:0]      bus_wdata_i,
    output logic                       aw_hit_o,
    output fuse_guard_pkg::reg_sel_t   aw_reg_o,
    output logic [`FG_USER_W-1:0]      aw_user_o,
    output logic                       wr_hit_o,
    output fuse_guard_pkg::reg_sel_t   wr_reg_o,
    output logic [`FG_USER_W-1:0]      wr_user_o,
    output logic [`FG_DATA_W-1:0]      wr_data_o
);
    import fuse_guard_pkg::*;

    reg_sel_t              addr_sel;
    reg_sel_t              pend_reg_q;
    logic [`FG_USER_W-1:0] pend_user_q;

    // Map the beat address onto the register window.
    // Anything outside the four offsets is still a write, but to no register.
    always_comb begin
        case (bus_addr_i)
            `FG_OFS_WDATA0:  addr_sel = REG_WDATA0;
            `FG_OFS_WDATA1:  addr_sel = REG_WDATA1;
            `FG_OFS_ADDRESS: addr_sel = REG_ADDRESS;
            `FG_OFS_CMD:     addr_sel = REG_CMD;
            default:         addr_sel = REG_NONE;
        endcase
    end

    // The pending select and user stay put until the next address beat.
    // That way the data beat one cycle later finds them still valid.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_hit_o    <= 1'b0;
            pend_reg_q  <= REG_NONE;
            pend_user_q <= '0;
            wr_hit_o    <= 1'b0;
            wr_reg_o    <= REG_NONE;
            wr_user_o   <= '0;
            wr_data_o   <= '0;
        end else begin
            aw_hit_o <= bus_aw_i;
            wr_hit_o <= bus_w_i;
            if (bus_aw_i) begin
                pend_reg_q  <= addr_sel;
                pend_user_q <= bus_user_i;
            end
            // Pair the data beat with the address beat before it.
            if (bus_w_i) begin
                wr_reg_o  <= pend_reg_q;
                wr_user_o <= pend_user_q;
                wr_data_o <= bus_wdata_i;
            end
        end
    end

    // The address side is reported in the cycle after the beat.
    assign aw_reg_o  = pend_reg_q;
    assign aw_user_o = pend_user_q;

endmodule

`default_nettype wire

//--- design/fuse_direct_access.sv
// Third pipeline stage; direct-access registers, fuse programming or discard, and fuse readback.

`timescale 1ns/1ps
`include "fuse_guard_cfg.svh"
`default_nettype none

module fuse_direct_access (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire                          wr_hit_i,
    input  fuse_guard_pkg::reg_sel_t     wr_reg_i,
    input  wire  [`FG_DATA_W-1:0]        wr_data_i,
    input  wire                          discard_i,
    input  wire  [`FG_FUSE_AW-1:0]       rd_addr_i,
    output logic [2*`FG_DATA_W-1:0]      rd_data_o,
    output logic                         prog_done_o,
    output logic                         discarded_o
);
    import fuse_guard_pkg::*;

    logic [`FG_DATA_W-1:0]   wdata0_q;
    logic [`FG_DATA_W-1:0]   wdata1_q;
    logic [`FG_FUSE_AW-1:0]  addr_q;
    logic                    cmd_pend_q;
    fuse_cmd_t               cmd_op_q;
    logic [2*`FG_DATA_W-1:0] fuse_q [`FG_FUSE_WORDS];

    // ------------------------------------------------------------------------
    // Register window.
    // ------------------------------------------------------------------------

    // A command sits in the pending slot for one cycle.
    // That gives the filter time to raise discard.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wdata0_q   <= '0;
            wdata1_q   <= '0;
            addr_q     <= '0;
            cmd_pend_q <= 1'b0;
            cmd_op_q   <= CMD_NOP;
        end else begin
            cmd_pend_q <= 1'b0;
            if (wr_hit_i) begin
                case (wr_reg_i)
                    REG_WDATA0:  wdata0_q <= wr_data_i;
                    REG_WDATA1:  wdata1_q <= wr_data_i;
                    REG_ADDRESS: addr_q   <= wr_data_i[`FG_FUSE_AW-1:0];
                    REG_CMD: begin
                        cmd_pend_q <= 1'b1;
                        cmd_op_q   <= fuse_cmd_t'(wr_data_i[1:0]);
                    end
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // Fuse array.
    // ------------------------------------------------------------------------

    // Fuses can only be blown, never cleared, so a program ORs the new bits in.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `FG_FUSE_WORDS; i++) begin
                fuse_q[i] <= '0;
            end
            prog_done_o <= 1'b0;
            discarded_o <= 1'b0;
        end else begin
            prog_done_o <= 1'b0;
            discarded_o <= 1'b0;
            if (cmd_pend_q) begin
                if (discard_i) begin
                    discarded_o <= 1'b1;
                end else if (cmd_op_q == CMD_PROGRAM) begin
                    fuse_q[addr_q] <= fuse_q[addr_q] | {wdata1_q, wdata0_q};
                    prog_done_o    <= 1'b1;
                end
            end
        end
    end

    // Readback is one cycle behind the address.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= fuse_q[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- design/fuse_guard_top.sv
// Top level of the fuse write guard; connects bus decode, write filter and fuse programmer.

`timescale 1ns/1ps
`include "fuse_guard_cfg.svh"
`default_nettype none

module fuse_guard_top (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire                          bus_aw_i,
    input  wire  [`FG_ADDR_W-1:0]        bus_addr_i,
    input  wire  [`FG_USER_W-1:0]        bus_user_i,
    input  wire                          bus_w_i,
    input  wire  [`FG_DATA_W-1:0]        bus_wdata_i,
    input  wire  [`FG_USER_W-1:0]        strap_user0_i,
    input  wire  [`FG_USER_W-1:0]        strap_user1_i,
    input  wire                          init_done_i,
    input  wire  [`FG_FUSE_AW-1:0]       rd_addr_i,
    output logic [2*`FG_DATA_W-1:0]      rd_data_o,
    output logic                         prog_done_o,
    output logic                         write_discarded_o
);
    import fuse_guard_pkg::*;

    logic                  aw_hit;
    reg_sel_t              aw_reg;
    logic [`FG_USER_W-1:0] aw_user;
    logic                  wr_hit;
    reg_sel_t              wr_reg;
    logic [`FG_DATA_W-1:0] wr_data;
    logic                  discard;
    logic                  discarded;

    // The filter takes users from the address side, so the paired data user is not routed on.
    fuse_bus_decode u_decode (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .bus_aw_i(bus_aw_i), .bus_addr_i(bus_addr_i), .bus_user_i(bus_user_i),
        .bus_w_i(bus_w_i), .bus_wdata_i(bus_wdata_i),
        .aw_hit_o(aw_hit), .aw_reg_o(aw_reg), .aw_user_o(aw_user),
        .wr_hit_o(wr_hit), .wr_reg_o(wr_reg), .wr_user_o(), .wr_data_o(wr_data)
    );

    fuse_write_filter u_filter (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .init_done_i(init_done_i),
        .strap_user0_i(strap_user0_i), .strap_user1_i(strap_user1_i),
        .aw_hit_i(aw_hit), .aw_reg_i(aw_reg), .aw_user_i(aw_user),
        .wr_hit_i(wr_hit), .wr_data_i(wr_data),
        .discarded_i(discarded), .discard_o(discard)
    );

    fuse_direct_access u_access (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .wr_hit_i(wr_hit), .wr_reg_i(wr_reg), .wr_data_i(wr_data),
        .discard_i(discard), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o),
        .prog_done_o(prog_done_o), .discarded_o(discarded)
    );

    // The discard acknowledge goes both back to the filter and out to the host.
    assign write_discarded_o = discarded;

endmodule

`default_nettype wire

//--- fuse_filter/fuse_write_filter.sv
// Second pipeline stage; snoops register writes and raises discard for a refused fuse command.

`timescale 1ns/1ps
`include "fuse_guard_cfg.svh"
`default_nettype none

module fuse_write_filter (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        init_done_i,
    input  wire  [`FG_USER_W-1:0]      strap_user0_i,
    input  wire  [`FG_USER_W-1:0]      strap_user1_i,
    input  wire                        aw_hit_i,
    input  fuse_guard_pkg::reg_sel_t   aw_reg_i,
    input  wire  [`FG_USER_W-1:0]      aw_user_i,
    input  wire                        wr_hit_i,
    input  wire  [`FG_DATA_W-1:0]      wr_data_i,
    input  wire                        discarded_i,
    output logic                       discard_o
);
    import fuse_guard_pkg::*;

    filter_state_t         state_q;
    filter_state_t         state_d;
    logic [`FG_DATA_W-1:0] fuse_addr_q;
    logic [`FG_USER_W-1:0] data_id0_q;
    logic [`FG_USER_W-1:0] data_id1_q;
    logic [`FG_USER_W-1:0] addr_id_q;
    logic [`FG_USER_W-1:0] cmd_id_q;
    logic                  latch_addr;
    logic                  latch_data_id0;
    logic                  latch_data_id1;
    logic                  latch_addr_id;
    logic                  latch_cmd_id;
    logic                  clear_records;
    logic                  discard_d;
    logic [1:0]            range_ok;
    logic                  wr_allowed;
    logic                  all_same_id;

    // ------------------------------------------------------------------------
    // Access table and user consistency.
    // ------------------------------------------------------------------------

    // Each entry allows its range only to its strap owner.
    // The first data user stands for the whole request; the others are checked below.
    assign range_ok[0] = (fuse_addr_q >= `FG_DATA_W'(`FG_RANGE0_LO))
                       && (fuse_addr_q <= `FG_DATA_W'(`FG_RANGE0_HI))
                       && (data_id0_q == strap_user0_i);
    assign range_ok[1] = (fuse_addr_q >= `FG_DATA_W'(`FG_RANGE1_LO))
                       && (fuse_addr_q <= `FG_DATA_W'(`FG_RANGE1_HI))
                       && (data_id0_q == strap_user1_i);
    assign wr_allowed  = |range_ok;

    // All four register writes must come from the same bus user.
    assign all_same_id = (data_id0_q == data_id1_q) && (data_id1_q == addr_id_q)
                       && (addr_id_q == cmd_id_q);

    // ------------------------------------------------------------------------
    // Next state and latch enables.
    // ------------------------------------------------------------------------
    always_comb begin
        state_d        = state_q;
        latch_addr     = 1'b0;
        latch_data_id0 = 1'b0;
        latch_data_id1 = 1'b0;
        latch_addr_id  = 1'b0;
        latch_cmd_id   = 1'b0;
        clear_records  = 1'b0;
        discard_d      = 1'b0;
        case (state_q)
            RESET_ST: begin
                // Wait for fuse initialization before snooping anything.
                clear_records = 1'b1;
                if (init_done_i) begin
                    state_d = IDLE_ST;
                end
            end
            IDLE_ST: begin
                // A request starts with either data register.
                if (aw_hit_i && aw_reg_i == REG_WDATA0) begin
                    latch_data_id0 = 1'b1;
                    state_d        = WDATA_ADDR_ST;
                end else if (aw_hit_i && aw_reg_i == REG_WDATA1) begin
                    latch_data_id1 = 1'b1;
                    state_d        = WDATA_ADDR_ST;
                end else begin
                    clear_records = 1'b1;
                end
            end
            WDATA_ADDR_ST: begin
                if (wr_hit_i) begin
                    state_d = WDATA_ST;
                end
            end
            WDATA_ST: begin
                // More data writes may follow before the address register.
                if (aw_hit_i && aw_reg_i == REG_ADDRESS) begin
                    latch_addr_id = 1'b1;
                    state_d       = FUSE_ADDR_AXI_ADDR_ST;
                end else if (aw_hit_i && aw_reg_i == REG_WDATA0) begin
                    latch_data_id0 = 1'b1;
                    state_d        = WDATA_ADDR_ST;
                end else if (aw_hit_i && aw_reg_i == REG_WDATA1) begin
                    latch_data_id1 = 1'b1;
                    state_d        = WDATA_ADDR_ST;
                end
            end
            FUSE_ADDR_AXI_ADDR_ST: begin
                // The data beat of the address register carries the fuse word address.
                if (wr_hit_i) begin
                    latch_addr = 1'b1;
                    state_d    = FUSE_ADDR_AXI_WR_ST;
                end
            end
            FUSE_ADDR_AXI_WR_ST: begin
                if (aw_hit_i && aw_reg_i == REG_CMD) begin
                    latch_cmd_id = 1'b1;
                    state_d      = FUSE_CMD_AXI_ADDR_ST;
                end
            end
            FUSE_CMD_AXI_ADDR_ST: begin
                // The check runs here, in the same cycle as the command data beat.
                if (!wr_allowed || !all_same_id) begin
                    discard_d = 1'b1;
                    state_d   = DISCARD_ST;
                end else if (wr_hit_i) begin
                    state_d = IDLE_ST;
                end
            end
            DISCARD_ST: begin
                // Hold discard until the programmer confirms it dropped the command.
                discard_d = 1'b1;
                if (discarded_i) begin
                    state_d = IDLE_ST;
                end
            end
            default: begin
                state_d = IDLE_ST;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // State, records and the registered discard level.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= RESET_ST;
            discard_o   <= 1'b0;
            fuse_addr_q <= '0;
            data_id0_q  <= '0;
            data_id1_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_q    <= '0;
        end else begin
            state_q   <= state_d;
            discard_o <= discard_d;
            if (clear_records) begin
                fuse_addr_q <= '0;
                data_id0_q  <= '0;
                data_id1_q  <= '0;
                addr_id_q   <= '0;
                cmd_id_q    <= '0;
            end else begin
                if (latch_addr) begin
                    fuse_addr_q <= wr_data_i;
                end
                // A write to data 0 also seeds data 1, so a single data write is consistent.
                if (latch_data_id0) begin
                    data_id0_q <= aw_user_i;
                    data_id1_q <= aw_user_i;
                end else if (latch_data_id1) begin
                    data_id1_q <= aw_user_i;
                end
                if (latch_addr_id) begin
                    addr_id_q <= aw_user_i;
                end
                if (latch_cmd_id) begin
                    cmd_id_q <= aw_user_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- fuse_guard.f
+incdir+common
common/fuse_guard_pkg.sv
design/fuse_bus_decode.sv
fuse_filter/fuse_write_filter.sv
design/fuse_direct_access.sv
design/fuse_guard_top.sv
bench/fuse_guard_chk.sv
bench/fuse_guard_monitor.sv
bench/fuse_guard_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the fuse guard testbench with Verilator, run it, and check for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fuse_guard_tb \
    -f fuse_guard.f -o fuse_guard_sim

result=$(./obj_dir/fuse_guard_sim +verilator+error+limit+100)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "sim passed"
